//--- ps2_line_pkg.sv
/*
  PS/2 line-protocol definitions shared by the bit engine.
  Frame size, bit counter and frame types, and the encoding of the
  receive/transmit state machine.
*/
package ps2_line_pkg;

  // start + 8 data + parity + stop
  localparam int frame_bits = 11;

  typedef logic [3:0]            bit_count_t;  // counts frame bits, 0..11
  typedef logic [frame_bits-1:0] frame_t;      // shift register contents

  // line state machine
  // rx_clk_l sits at 0 so an unreset machine walks harmlessly into rx_clk_h
  typedef enum logic [3:0] {
    rx_clk_l            = 4'd0,
    rx_clk_h            = 4'd1,
    tx_wait_clk_h       = 4'd2,   // wait for keyboard clock high, debounced
    tx_force_clk_l      = 4'd3,   // hold clock low for the inhibit time
    tx_clk_h            = 4'd4,
    tx_clk_l            = 4'd5,
    tx_wait_ack         = 4'd6,   // data released, keyboard answers on next low clock
    tx_done_recovery    = 4'd7,
    tx_no_ack           = 4'd8,   // keyboard left data high at ack time
    tx_rise_mark        = 4'd9,   // one cycle, shifts the next tx bit out
    tx_first_wait_clk_h = 4'd10,  // start bit driven, wait for first keyboard clock
    tx_reset_timer      = 4'd12,
    rx_fall_mark        = 4'd13,  // one cycle, samples a rx bit
    rx_rise_mark        = 4'd14
  } line_state_t;

endpackage

//--- kbd_code_pkg.sv
/*
  Keyboard scan code definitions for the translator and the top level.
  Holds the code and character types and the scan set 2 prefixes and
  shift keys.
*/
package kbd_code_pkg;

  typedef logic [7:0] scan_code_t;  // one keyboard scan code byte
  typedef logic [7:0] ascii_t;      // one ASCII character

  //------------------------------------------------------------
  // prefix codes
  //------------------------------------------------------------

  localparam scan_code_t extend_code  = 8'he0;  // extended key follows
  localparam scan_code_t release_code = 8'hf0;  // break code follows

  //------------------------------------------------------------
  // modifier keys
  //------------------------------------------------------------

  localparam scan_code_t left_shift_code  = 8'h12;
  localparam scan_code_t right_shift_code = 8'h59;

endpackage

//--- ps2_line_engine.sv
/*
  Open-drain PS/2 bit engine. Receives 11-bit frames from the keyboard and
  sends 8-bit commands with odd parity. Lines are sampled through two flops;
  the *_low outputs pull the line down when high.
*/
`timescale 1ns/1ps

module ps2_line_engine
  import ps2_line_pkg::*, kbd_code_pkg::*;
#(
  parameter int inhibit_cycles  = 3000,  // clk cycles in 60 us
  parameter int debounce_cycles = 250    // clk cycles in 5 us
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_in,
  input  logic       ps2_data_in,
  output logic       ps2_clk_low,
  output logic       ps2_data_low,
  input  scan_code_t tx_data,
  input  logic       tx_write,
  output logic       tx_write_ack,
  output logic       tx_no_ack,
  output logic       frame_done,
  output scan_code_t frame_code
);

  localparam int inhibit_w  = $clog2(inhibit_cycles + 1);
  localparam int debounce_w = $clog2(debounce_cycles + 1);

  typedef logic [inhibit_w-1:0]  inhibit_count_t;
  typedef logic [debounce_w-1:0] debounce_count_t;

  logic            clk_meta, clk_s;    // clock line synchronizer
  logic            data_meta, data_s;  // data line synchronizer
  line_state_t     state, next_state;
  bit_count_t      bit_count;
  frame_t          shift_q;
  logic            inhibit_en, inhibit_done;
  logic            debounce_en, debounce_done;
  logic            tx_bits_done;
  logic            bit_step;
  inhibit_count_t  inhibit_count;
  debounce_count_t debounce_count;

  // idle level of both lines is high
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_meta  <= 1'b1;
      clk_s     <= 1'b1;
      data_meta <= 1'b1;
      data_s    <= 1'b1;
    end
    else
    begin
      clk_meta  <= ps2_clk_in;
      clk_s     <= clk_meta;
      data_meta <= ps2_data_in;
      data_s    <= data_meta;
    end
  end

  //------------------------------------------------------------
  // state machine
  //------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset) state <= rx_clk_h;
    else       state <= next_state;
  end

  always_comb
  begin
    next_state  = state;
    inhibit_en  = 1'b0;
    debounce_en = 1'b0;
    case (state)
      rx_clk_h:
      begin
        inhibit_en = 1'b1;  // doubles as rx watchdog
        if (tx_write)    next_state = tx_reset_timer;
        else if (!clk_s) next_state = rx_fall_mark;
      end
      rx_fall_mark: next_state = rx_clk_l;
      rx_clk_l:
      begin
        inhibit_en = 1'b1;
        if (tx_write)   next_state = tx_reset_timer;
        else if (clk_s) next_state = rx_rise_mark;
      end
      rx_rise_mark:   next_state = rx_clk_h;
      tx_reset_timer: next_state = tx_force_clk_l;  // restarts the 60 us count
      tx_force_clk_l:
      begin
        inhibit_en = 1'b1;
        if (inhibit_done) next_state = tx_first_wait_clk_h;
      end
      tx_first_wait_clk_h:
      begin
        debounce_en = 1'b1;
        // keyboard may take a long time before its first clock
        if (!clk_s && debounce_done) next_state = tx_clk_l;
      end
      tx_wait_clk_h:
      begin
        debounce_en = 1'b1;
        if (clk_s && debounce_done) next_state = tx_rise_mark;
      end
      tx_rise_mark: next_state = tx_clk_h;
      tx_clk_h:
      begin
        if (tx_bits_done) next_state = tx_wait_ack;
        else if (!clk_s)  next_state = tx_clk_l;
      end
      tx_clk_l: if (clk_s) next_state = tx_wait_clk_h;
      tx_wait_ack:
      begin
        // keyboard pulls data low with its ack clock
        if (!clk_s) next_state = data_s ? ps2_line_pkg::tx_no_ack : tx_done_recovery;
      end
      tx_done_recovery, ps2_line_pkg::tx_no_ack:
      begin
        if (clk_s && data_s) next_state = rx_clk_h;  // both lines released
      end
      default: next_state = rx_clk_h;
    endcase
  end

  //------------------------------------------------------------
  // timers, saturate at their terminal count
  //------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset || !inhibit_en) inhibit_count <= '0;
    else if (!inhibit_done)   inhibit_count <= inhibit_count + 1'b1;
  end
  assign inhibit_done = (inhibit_count == inhibit_count_t'(inhibit_cycles - 1));

  always_ff @(posedge clk)
  begin
    if (reset || !debounce_en) debounce_count <= '0;
    else if (!debounce_done)   debounce_count <= debounce_count + 1'b1;
  end
  assign debounce_done = (debounce_count == debounce_count_t'(debounce_cycles - 1));

  //------------------------------------------------------------
  // bit counter and shift register
  //------------------------------------------------------------

  assign bit_step = (state == rx_fall_mark) || (state == tx_rise_mark);

  always_ff @(posedge clk)
  begin
    if (reset || frame_done || state == tx_reset_timer || state == tx_wait_ack)
      bit_count <= '0;
    else if (inhibit_done && state == rx_clk_h && clk_s)
      bit_count <= '0;  // clock idle too long, drop a partial frame
    else if (bit_step)
      bit_count <= bit_count + 4'd1;
  end

  assign frame_done   = (bit_count == bit_count_t'(frame_bits));
  assign tx_bits_done = (bit_count == bit_count_t'(frame_bits - 1));  // stop bit left

  // loads stop, odd parity, command and start; shifts lsb first both ways
  always_ff @(posedge clk)
  begin
    if (tx_write_ack)  shift_q <= {1'b1, ~^tx_data, tx_data, 1'b0};
    else if (bit_step) shift_q <= {data_s, shift_q[frame_bits-1:1]};
  end

  assign frame_code   = shift_q[8:1];
  assign tx_write_ack = tx_write && (state == rx_clk_h || state == rx_clk_l);
  assign tx_no_ack    = (state == ps2_line_pkg::tx_no_ack);
  assign ps2_clk_low  = (state == tx_force_clk_l);  // inhibit

  always_comb
  begin
    case (state)
      tx_first_wait_clk_h: ps2_data_low = 1'b1;  // start bit
      tx_wait_clk_h, tx_rise_mark, tx_clk_h, tx_clk_l:
        ps2_data_low = ~shift_q[0];
      default: ps2_data_low = 1'b0;
    endcase
  end

endmodule

//--- scan_translator.sv
/*
  Turns completed PS/2 frames into key events. Tracks the E0 and F0
  prefixes and both shift keys, maps codes to ASCII on the UK layout,
  and holds rx_data_ready until rx_read.
*/
`timescale 1ns/1ps

module scan_translator
  import kbd_code_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       frame_done,
  input  scan_code_t frame_code,
  input  logic       rx_read,
  output scan_code_t rx_scan_code,
  output ascii_t     rx_ascii,
  output logic       rx_extended,
  output logic       rx_released,
  output logic       rx_shift_key_on,
  output logic       rx_data_ready
);

  logic   is_extend, is_release, key_event;
  logic   hold_extended, hold_released;
  logic   left_shift, right_shift;
  ascii_t letter_char;  // lower case letter, 0 when not a letter
  ascii_t table_char;
  ascii_t key_ascii;

  assign is_extend  = (frame_code == extend_code);
  assign is_release = (frame_code == release_code);
  assign key_event  = frame_done && !is_extend && !is_release;

  // prefixes held until the key code that follows them
  always_ff @(posedge clk)
  begin
    if (reset || key_event)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_extend)  hold_extended <= 1'b1;
      if (is_release) hold_released <= 1'b1;
    end
  end

  // make sets, break clears
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
    end
    else if (frame_done)
    begin
      if (frame_code == left_shift_code)  left_shift  <= !hold_released;
      if (frame_code == right_shift_code) right_shift <= !hold_released;
    end
  end

  assign rx_shift_key_on = left_shift || right_shift;

  //------------------------------------------------------------
  // ascii lookup
  //------------------------------------------------------------

  always_comb
  begin
    case (frame_code)
      8'h1c: letter_char = 8'h61;  // a
      8'h32: letter_char = 8'h62;
      8'h21: letter_char = 8'h63;
      8'h23: letter_char = 8'h64;
      8'h24: letter_char = 8'h65;  // e
      8'h2b: letter_char = 8'h66;
      8'h34: letter_char = 8'h67;
      8'h33: letter_char = 8'h68;
      8'h43: letter_char = 8'h69;  // i
      8'h3b: letter_char = 8'h6a;
      8'h42: letter_char = 8'h6b;
      8'h4b: letter_char = 8'h6c;
      8'h3a: letter_char = 8'h6d;
      8'h31: letter_char = 8'h6e;  // n
      8'h44: letter_char = 8'h6f;
      8'h4d: letter_char = 8'h70;
      8'h15: letter_char = 8'h71;
      8'h2d: letter_char = 8'h72;  // r
      8'h1b: letter_char = 8'h73;
      8'h2c: letter_char = 8'h74;
      8'h3c: letter_char = 8'h75;
      8'h2a: letter_char = 8'h76;  // v
      8'h1d: letter_char = 8'h77;
      8'h22: letter_char = 8'h78;
      8'h35: letter_char = 8'h79;
      8'h1a: letter_char = 8'h7a;  // z
      default: letter_char = 8'h00;
    endcase
  end

  // {shift, code}, upper bit ? where shift does not matter
  always_comb
  begin
    casez ({rx_shift_key_on, frame_code})
      9'b?_0110_0110: table_char = 8'h08;  // backspace
      9'b?_0000_1101: table_char = 8'h09;  // tab
      9'b?_0101_1010: table_char = 8'h0d;  // enter
      9'b?_0111_0110: table_char = 8'h1b;  // escape
      9'b?_0010_1001: table_char = 8'h20;  // space
      9'h045: table_char = 8'h30;  // 0
      9'h016: table_char = 8'h31;
      9'h01e: table_char = 8'h32;
      9'h026: table_char = 8'h33;
      9'h025: table_char = 8'h34;
      9'h02e: table_char = 8'h35;  // 5
      9'h036: table_char = 8'h36;
      9'h03d: table_char = 8'h37;
      9'h03e: table_char = 8'h38;
      9'h046: table_char = 8'h39;  // 9
      9'h116: table_char = 8'h21;  // !
      9'h11e: table_char = 8'h22;  // double quote on shift 2
      9'h126: table_char = 8'h23;  // # stands in for the pound sign
      9'h125: table_char = 8'h24;  // $
      9'h12e: table_char = 8'h25;  // %
      9'h136: table_char = 8'h5e;  // ^
      9'h13d: table_char = 8'h26;  // &
      9'h13e: table_char = 8'h2a;  // *
      9'h146: table_char = 8'h28;  // (
      9'h145: table_char = 8'h29;  // )
      9'h052: table_char = 8'h27;  // single quote
      9'h041: table_char = 8'h2c;  // comma
      9'h04e: table_char = 8'h2d;  // -
      9'h049: table_char = 8'h2e;  // .
      9'h04a: table_char = 8'h2f;  // /
      9'h04c: table_char = 8'h3b;  // ;
      9'h055: table_char = 8'h3d;  // =
      9'h054: table_char = 8'h5b;  // [
      9'h05b: table_char = 8'h5d;  // ]
      9'h00e: table_char = 8'h60;  // backtick
      9'h061: table_char = 8'h5c;  // backslash, key left of z
      9'h05d: table_char = 8'h23;  // # next to enter
      9'h152: table_char = 8'h40;  // @
      9'h141: table_char = 8'h3c;  // <
      9'h14e: table_char = 8'h5f;  // _
      9'h149: table_char = 8'h3e;  // >
      9'h14a: table_char = 8'h3f;  // ?
      9'h14c: table_char = 8'h3a;  // :
      9'h155: table_char = 8'h2b;  // +
      9'h154: table_char = 8'h7b;  // {
      9'h15b: table_char = 8'h7d;  // }
      9'h10e: table_char = 8'h7c;  // | on shift backtick
      9'h161: table_char = 8'h7c;  // | on shift backslash
      9'h15d: table_char = 8'h7e;  // ~
      default: table_char = 8'h3f;  // unlisted codes show as ?
    endcase
  end

  always_comb
  begin
    if (letter_char == 8'h00)  key_ascii = table_char;
    else if (rx_shift_key_on)  key_ascii = letter_char - 8'h20;  // upper case
    else                       key_ascii = letter_char;
  end

  //------------------------------------------------------------
  // event outputs, overwritten when a new key arrives
  //------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_scan_code  <= '0;
      rx_ascii      <= '0;
      rx_extended   <= 1'b0;
      rx_released   <= 1'b0;
      rx_data_ready <= 1'b0;
    end
    else if (key_event)
    begin
      rx_scan_code  <= frame_code;
      rx_ascii      <= key_ascii;
      rx_extended   <= hold_extended;
      rx_released   <= hold_released;
      rx_data_ready <= 1'b1;
    end
    else if (rx_read)
      rx_data_ready <= 1'b0;
  end

endmodule

//--- ps2_keyboard.sv
/*
  PS/2 keyboard host top level. Joins the line engine and the scan code
  translator. Timer lengths are set here for the system clock in use.
*/
`timescale 1ns/1ps

module ps2_keyboard
  import kbd_code_pkg::*;
#(
  parameter int inhibit_cycles  = 3000,  // 60 us at 50 MHz
  parameter int debounce_cycles = 250    // 5 us at 50 MHz
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_in,
  input  logic       ps2_data_in,
  output logic       ps2_clk_low,      // high pulls the clock line down
  output logic       ps2_data_low,     // high pulls the data line down
  input  scan_code_t tx_data,
  input  logic       tx_write,         // hold until tx_write_ack
  output logic       tx_write_ack,
  output logic       tx_no_ack,
  input  logic       rx_read,          // one cycle, clears rx_data_ready
  output scan_code_t rx_scan_code,
  output ascii_t     rx_ascii,
  output logic       rx_extended,
  output logic       rx_released,
  output logic       rx_shift_key_on,
  output logic       rx_data_ready
);

  logic       frame_done;
  scan_code_t frame_code;

  ps2_line_engine #(
    .inhibit_cycles  (inhibit_cycles),
    .debounce_cycles (debounce_cycles)
  ) i_engine (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk_in   (ps2_clk_in),
    .ps2_data_in  (ps2_data_in),
    .ps2_clk_low  (ps2_clk_low),
    .ps2_data_low (ps2_data_low),
    .tx_data      (tx_data),
    .tx_write     (tx_write),
    .tx_write_ack (tx_write_ack),
    .tx_no_ack    (tx_no_ack),
    .frame_done   (frame_done),
    .frame_code   (frame_code)
  );

  scan_translator i_translator (
    .clk             (clk),
    .reset           (reset),
    .frame_done      (frame_done),
    .frame_code      (frame_code),
    .rx_read         (rx_read),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_data_ready   (rx_data_ready)
  );

endmodule

//--- tb_clock_gen.sv
/*
  Testbench clock and reset source. 20 ns clock; reset is held high
  for the first cycles and released on a falling edge.
*/
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period_ns = 10,  // 20 ns period
  parameter int reset_cycles   = 5
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;  // away from the sampling edge
  end

endmodule

//--- ps2_keyboard_assert.sv
/*
  Concurrent checks on the PS/2 keyboard host ports. Bound into every
  ps2_keyboard instance by the bind statement at the end of this file.
*/
`timescale 1ns/1ps

module ps2_keyboard_assert (
  input logic clk,
  input logic reset,
  input logic ps2_clk_low,
  input logic ps2_data_low,
  input logic tx_write_ack,
  input logic tx_no_ack,
  input logic rx_read,
  input logic rx_data_ready
);

  // synchronous reset, outputs quiet one edge after reset is seen
  a_reset_idle: assert property (@(posedge clk)
    reset |=> (!rx_data_ready && !tx_no_ack && !ps2_clk_low && !ps2_data_low))
    else $error("outputs still active after reset");

  // a command is only taken while the host drives neither line
  a_ack_idle: assert property (@(posedge clk) disable iff (reset)
    tx_write_ack |-> (!ps2_clk_low && !ps2_data_low))
    else $error("tx_write_ack while a pull-down is active");

  a_read_clears: assert property (@(posedge clk) disable iff (reset)
    (rx_read && rx_data_ready) |=> !rx_data_ready)
    else $error("rx_data_ready not cleared one cycle after rx_read");

  //------------------------------------------------------------
  // inhibit and start bit
  //------------------------------------------------------------

  // data stays released while the clock is held down
  a_inhibit_data: assert property (@(posedge clk) disable iff (reset)
    ps2_clk_low |-> !ps2_data_low)
    else $error("data pulled low during clock inhibit");

  a_start_bit: assert property (@(posedge clk) disable iff (reset)
    $fell(ps2_clk_low) |-> ps2_data_low)  // start bit as inhibit ends
    else $error("no start bit when the clock inhibit ends");

endmodule

bind ps2_keyboard ps2_keyboard_assert i_assert (
  .clk           (clk),
  .reset         (reset),
  .ps2_clk_low   (ps2_clk_low),
  .ps2_data_low  (ps2_data_low),
  .tx_write_ack  (tx_write_ack),
  .tx_no_ack     (tx_no_ack),
  .rx_read       (rx_read),
  .rx_data_ready (rx_data_ready)
);

//--- tb_ps2_keyboard.sv
/*
  Testbench for the PS/2 keyboard host. A keyboard model sends frames
  and takes commands on a wired-AND bus; immediate assertions check the
  key events and commands, one line is printed per test.
*/
`timescale 1ns/1ps

module tb_ps2_keyboard;

  localparam int half_period = 20;   // keyboard clock half-period in clk cycles
  localparam int inhibit     = 100;
  localparam int sel_ready   = 0;    // signals watched by wait_level
  localparam int sel_clk_low = 1;
  localparam int sel_no_ack  = 2;

  logic       clk, reset;
  logic       kbd_clk, kbd_data;            // keyboard side of the bus
  logic       ps2_clk_line, ps2_data_line;  // resolved lines
  logic       ps2_clk_low, ps2_data_low;
  logic [7:0] tx_data;
  logic       tx_write, tx_write_ack, tx_no_ack;
  logic       rx_read;
  logic [7:0] rx_scan_code, rx_ascii;
  logic       rx_extended, rx_released, rx_shift_key_on, rx_data_ready;

  integer     seed;
  int         error_count, test_count, failed_count, errors_at_start;
  int         idx, count;
  string      test_name;
  logic [7:0] code, shift, cmd;
  logic       seen_low, seen_high;
  logic [7:0] key_code [0:7];  // six letters, then two digits
  logic [7:0] key_char [0:7];  // unshifted ascii

  tb_clock_gen i_clock_gen (.clk(clk), .reset(reset));

  // open-drain bus, either side can pull down
  assign ps2_clk_line  = kbd_clk & ~ps2_clk_low;
  assign ps2_data_line = kbd_data & ~ps2_data_low;

  ps2_keyboard #(
    .inhibit_cycles  (inhibit),
    .debounce_cycles (8)
  ) i_ps2_keyboard (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk_in      (ps2_clk_line),
    .ps2_data_in     (ps2_data_line),
    .ps2_clk_low     (ps2_clk_low),
    .ps2_data_low    (ps2_data_low),
    .tx_data         (tx_data),
    .tx_write        (tx_write),
    .tx_write_ack    (tx_write_ack),
    .tx_no_ack       (tx_no_ack),
    .rx_read         (rx_read),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_data_ready   (rx_data_ready)
  );

  //------------------------------------------------------------
  // checking and reporting
  //------------------------------------------------------------

  task automatic check_value(input string what, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual == expected)
    else
    begin
      $display("MISMATCH %s: %s expected %h actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    assert (actual == expected)
    else
    begin
      $display("MISMATCH %s: %s expected %b actual %b", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic end_test;
    if (error_count == errors_at_start)
      $display("test %-10s ok", test_name);
    else
    begin
      $display("test %-10s failed with %0d errors", test_name, error_count - errors_at_start);
      failed_count++;
    end
  endtask

  task automatic finish_run;
    $display("tests %0d, failed %0d, errors %0d", test_count, failed_count, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("timeout in test %s: %s never came", test_name, what);
    error_count++;
    end_test;
    finish_run;
  endtask

  function automatic logic watch_signal(input int sel);
    case (sel)
      sel_ready:   return rx_data_ready;
      sel_clk_low: return ps2_clk_low;
      default:     return tx_no_ack;
    endcase
  endfunction

  // polls on falling edges, outputs are settled there
  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what);
    int waited;
    waited = 0;
    while (watch_signal(sel) != level)
    begin
      if (waited == limit) give_up(what);
      @(negedge clk);
      waited++;
    end
  endtask

  function automatic int pick(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  //------------------------------------------------------------
  // keyboard model
  //------------------------------------------------------------

  // start, 8 data lsb first, odd parity, stop; data moves while clock high
  task automatic send_frame(input logic [7:0] byte_out);
    logic [10:0] frame;
    frame = {1'b1, ~^byte_out, byte_out, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      kbd_data = frame[i];
      repeat (half_period) @(negedge clk);
      kbd_clk = 1'b0;
      repeat (half_period) @(negedge clk);
      kbd_clk = 1'b1;
    end
    kbd_data = 1'b1;
    repeat (half_period) @(negedge clk);  // idle gap
  endtask

  // clocks a command in, leaves the clock low on the ack pulse
  task automatic receive_command(input logic [7:0] expected, input logic give_ack);
    logic [9:0] bits;
    wait_level(sel_clk_low, 1'b1, 20, "clock inhibit");
    wait_level(sel_clk_low, 1'b0, inhibit + 20, "end of clock inhibit");
    for (int i = 0; i < 11; i++)
    begin
      if (i == 10 && give_ack) kbd_data = 1'b0;
      repeat (half_period) @(negedge clk);
      kbd_clk = 1'b0;
      if (i < 10)
      begin
        repeat (half_period) @(negedge clk);
        kbd_clk = 1'b1;
        bits[i] = ps2_data_line;  // read on the rising edge
      end
    end
    check_bit("start bit", 1'b0, bits[0]);
    check_value("command", expected, bits[8:1]);
    check_bit("parity", ~^expected, bits[9]);
  endtask

  task automatic release_lines;
    kbd_clk  = 1'b1;
    kbd_data = 1'b1;
  endtask

  //------------------------------------------------------------
  // host side
  //------------------------------------------------------------

  task automatic write_command(input logic [7:0] byte_out);
    int waited;
    waited   = 0;
    tx_data  = byte_out;
    tx_write = 1'b1;
    #1;
    while (!tx_write_ack)
    begin
      if (waited == 50) give_up("tx_write_ack");
      @(negedge clk);
      #1;
      waited++;
    end
    check_value("ack delay", 8'd0, 8'(waited));  // same cycle when idle
    @(negedge clk);
    tx_write = 1'b0;
  endtask

  task automatic read_event;
    rx_read = 1'b1;
    @(negedge clk);
    rx_read = 1'b0;
    check_bit("rx_data_ready after rx_read", 1'b0, rx_data_ready);
  endtask

  task automatic watch_no_ack(output logic seen);
    seen = 1'b0;
    repeat (half_period)
    begin
      @(negedge clk);
      seen = seen | tx_no_ack;
    end
  endtask

  //------------------------------------------------------------
  // tests
  //------------------------------------------------------------

  initial
  begin
    seed     = 32'hf0b153ed;
    kbd_clk  = 1'b1;
    kbd_data = 1'b1;
    tx_data  = 8'h00;
    tx_write = 1'b0;
    rx_read  = 1'b0;
    error_count  = 0;
    test_count   = 0;
    failed_count = 0;
    key_code = '{8'h1c, 8'h32, 8'h24, 8'h2d, 8'h3b, 8'h1a, 8'h16, 8'h46};
    key_char = '{8'h61, 8'h62, 8'h65, 8'h72, 8'h6a, 8'h7a, 8'h31, 8'h39};

    start_test("reset");
    count = 0;
    while (reset)
    begin
      if (count == 20) give_up("reset release");
      @(negedge clk);
      count++;
    end
    check_bit("rx_data_ready", 1'b0, rx_data_ready);
    check_bit("tx_no_ack", 1'b0, tx_no_ack);
    check_bit("ps2_clk_low", 1'b0, ps2_clk_low);
    check_bit("ps2_data_low", 1'b0, ps2_data_low);
    end_test;

    start_test("letter");
    idx = pick(6);
    send_frame(key_code[idx]);
    wait_level(sel_ready, 1'b1, 100, "rx_data_ready for the letter");
    check_value("rx_scan_code", key_code[idx], rx_scan_code);
    check_value("rx_ascii", key_char[idx], rx_ascii);
    check_bit("rx_extended", 1'b0, rx_extended);
    check_bit("rx_released", 1'b0, rx_released);
    read_event;
    end_test;

    start_test("shift");
    shift = pick(2) ? 8'h59 : 8'h12;  // right or left shift
    send_frame(shift);
    wait_level(sel_ready, 1'b1, 100, "rx_data_ready for shift make");
    check_bit("rx_shift_key_on", 1'b1, rx_shift_key_on);
    read_event;
    idx = pick(6);
    send_frame(key_code[idx]);
    wait_level(sel_ready, 1'b1, 100, "rx_data_ready for the shifted letter");
    check_value("rx_ascii", key_char[idx] - 8'h20, rx_ascii);  // upper case
    check_bit("rx_shift_key_on", 1'b1, rx_shift_key_on);
    read_event;
    send_frame(8'hf0);
    check_bit("rx_data_ready after F0", 1'b0, rx_data_ready);
    send_frame(shift);
    wait_level(sel_ready, 1'b1, 100, "rx_data_ready for shift break");
    check_value("rx_scan_code", shift, rx_scan_code);
    check_bit("rx_released", 1'b1, rx_released);
    check_bit("rx_shift_key_on", 1'b0, rx_shift_key_on);
    read_event;
    end_test;

    start_test("extended");
    send_frame(8'he0);
    check_bit("rx_data_ready after E0", 1'b0, rx_data_ready);
    idx = pick(8);
    send_frame(key_code[idx]);
    wait_level(sel_ready, 1'b1, 100, "rx_data_ready for the extended key");
    check_value("rx_scan_code", key_code[idx], rx_scan_code);
    check_value("rx_ascii", key_char[idx], rx_ascii);
    check_bit("rx_extended", 1'b1, rx_extended);
    read_event;
    code = key_code[pick(8)];
    send_frame(code);
    wait_level(sel_ready, 1'b1, 100, "rx_data_ready for the plain key");
    check_value("rx_scan_code", code, rx_scan_code);
    check_bit("rx_extended", 1'b0, rx_extended);  // prefix held for one key only
    read_event;
    end_test;

    start_test("cmd_ack");
    cmd = 8'($random(seed));
    write_command(cmd);
    receive_command(cmd, 1'b1);
    watch_no_ack(seen_low);
    release_lines;
    watch_no_ack(seen_high);
    check_bit("tx_no_ack seen", 1'b0, seen_low | seen_high);
    end_test;

    start_test("cmd_no_ack");
    cmd = 8'($random(seed));
    write_command(cmd);
    receive_command(cmd, 1'b0);
    wait_level(sel_no_ack, 1'b1, half_period, "tx_no_ack after a missing ack");
    repeat (half_period) @(negedge clk);  // clock still held low by the model
    check_bit("tx_no_ack held", 1'b1, tx_no_ack);
    release_lines;
    wait_level(sel_no_ack, 1'b0, 20, "tx_no_ack clear after line release");
    end_test;

    finish_run;
  end

endmodule

//--- all.f
ps2_line_pkg.sv
kbd_code_pkg.sv
ps2_line_engine.sv
scan_translator.sv
ps2_keyboard.sv
tb_clock_gen.sv
ps2_keyboard_assert.sv
tb_ps2_keyboard.sv

//--- run.sh
#!/bin/bash
# Build and run the PS/2 keyboard testbench with Verilator.
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module tb_ps2_keyboard -f all.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
